// File: Makefile
# Verilator flow for the shared RAM subsystem
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       := tb_shouse_tri
FILELIST  := shouse_tri.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) tb/shouse_tri_golden.txt
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/shouse_cen_gen.sv
// Interleaved clock enables for the sound CPU and the MCU
// One-cycle strobes, sound at phase 0 and MCU half a period later
// First sound strobe in the first cycle after rst_n is released
// Both strobes forced low whenever rst_n is low
`timescale 1ns/10ps
`default_nettype none

module shouse_cen_gen (
    input  wire  clk,
    input  wire  rst_n,
    output logic snd_cen,   // Sound CPU enable
    output logic mcu_cen    // MCU enable
);

    logic [shouse_pkg::CEN_W-1:0] phase;   // Position inside one strobe period
    logic                         run;     // Set once reset is gone

    // Phase only advances while running
    // so phase 0 lines up with the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
            run   <= 1'b0;
        end else begin
            run <= 1'b1;
            if (run) begin
                if (phase == shouse_pkg::PH_LAST) begin
                    phase <= '0;   // Wrap at end of period
                end else begin
                    phase <= phase + shouse_pkg::CEN_W'(1);
                end
            end
        end
    end

    // Decodes are mutually exclusive by construction
    assign snd_cen = rst_n && run && (phase == shouse_pkg::PH_SND);
    assign mcu_cen = rst_n && run && (phase == shouse_pkg::PH_MCU);  // Half period later

endmodule

`default_nettype wire

// File: rtl/shouse_dual_ram.sv
// True dual-port RAM on a single clock
// Depth and width fixed by the package
// Read data registered, one clock after the address, regardless of write enable
// Read during write returns old data on both ports
// Same-address writes in one cycle keep port 0 data
// No reset on the array or the read registers
`timescale 1ns/10ps
`default_nettype none

module shouse_dual_ram (
    input  wire                           clk,

    // Port 0
    input  wire                           we0,
    input  wire  [shouse_pkg::ADDR_W-1:0] addr0,
    input  wire  [shouse_pkg::DATA_W-1:0] wdata0,
    output logic [shouse_pkg::DATA_W-1:0] rdata0,

    // Port 1
    input  wire                           we1,
    input  wire  [shouse_pkg::ADDR_W-1:0] addr1,
    input  wire  [shouse_pkg::DATA_W-1:0] wdata1,
    output logic [shouse_pkg::DATA_W-1:0] rdata1
);

    // Storage
    logic [shouse_pkg::DATA_W-1:0] mem [shouse_pkg::DEPTH];

    logic collide;      // Both ports writing one word
    logic we1_eff;      // Port 1 write after priority

    assign collide = we0 && we1 && (addr0 == addr1);
    assign we1_eff = we1 && !collide;  // Port 0 wins a collision

    // Both ports read and write on the same edge
    always_ff @(posedge clk) begin
        rdata0 <= mem[addr0];           // Old contents on read-during-write
        rdata1 <= mem[addr1];           // Old contents here too
        if (we0) begin
            mem[addr0] <= wdata0;
        end
        if (we1_eff) begin
            mem[addr1] <= wdata1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/shouse_pkg.sv
// Sizes, requester bus and strobe timing shared by the tri-port RAM blocks
// RAM geometry is fixed by the board at 2K x 8
// CEN_PERIOD must be even so the MCU strobe lands at half period
`default_nettype none

package shouse_pkg;

    // Memory geometry
    localparam int ADDR_W = 11;            // 2048 words
    localparam int DATA_W = 8;
    localparam int DEPTH  = 1 << ADDR_W;

    // Clock-enable timing
    localparam int CEN_PERIOD = 4;         // Cycles between sound strobes
    localparam int CEN_W      = $clog2(CEN_PERIOD);

    // Phase values that fire each strobe
    localparam logic [CEN_W-1:0] PH_SND  = '0;
    localparam logic [CEN_W-1:0] PH_MCU  = CEN_W'(CEN_PERIOD / 2);
    localparam logic [CEN_W-1:0] PH_LAST = CEN_W'(CEN_PERIOD - 1);

    // One requester access, 21 bits
    typedef struct packed {
        logic              cs;             // Chip select
        logic              rnw;            // 1 = read
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } cpu_bus_t;

    // Current owner of RAM port 1
    typedef enum logic {
        SEL_MCU = 1'b0,
        SEL_SND = 1'b1
    } port_sel_t;

endpackage

`default_nettype wire

// File: rtl/shouse_tri_top.sv
// Shared RAM subsystem with its own strobe generator
// Strobes go out so the external CPUs run on the same enables
// Read data one clock after the request on both outputs
`timescale 1ns/10ps
`default_nettype none

module shouse_tri_top (
    input  wire                           clk,
    input  wire                           rst_n,

    // Requesters
    input  wire  shouse_pkg::cpu_bus_t    bus_req,
    input  wire  shouse_pkg::cpu_bus_t    mcu_req,
    input  wire  shouse_pkg::cpu_bus_t    snd_req,

    // Read data
    output logic [shouse_pkg::DATA_W-1:0] bus_rdata,
    output logic [shouse_pkg::DATA_W-1:0] alt_rdata,

    // Clock enables for external CPUs
    output logic                          snd_cen,
    output logic                          mcu_cen
);

    // Strobe generator
    shouse_cen_gen u_cen (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .snd_cen ( snd_cen ),
        .mcu_cen ( mcu_cen )
    );

    // Tri-port RAM, same strobes drive port 1 ownership
    shouse_triram u_triram (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .snd_cen   ( snd_cen   ),
        .mcu_cen   ( mcu_cen   ),
        .bus_req   ( bus_req   ),
        .mcu_req   ( mcu_req   ),
        .snd_req   ( snd_req   ),
        .bus_rdata ( bus_rdata ),
        .alt_rdata ( alt_rdata )
    );

endmodule

`default_nettype wire

// File: rtl/shouse_triram.sv
// Tri-port shared RAM built on one dual-port array
// Port 0 always serves the main bus (main and sub CPUs)
// Port 1 alternates between sound CPU and MCU, owner set by the last strobe
// Port 1 write lands only on the closing edge of the owner's window
// No wait states, a request outside its window is ignored on port 1
`timescale 1ns/10ps
`default_nettype none

module shouse_triram (
    input  wire                           clk,
    input  wire                           rst_n,

    input  wire                           snd_cen,
    input  wire                           mcu_cen,

    input  wire  shouse_pkg::cpu_bus_t    bus_req,    // Main and sub CPUs
    input  wire  shouse_pkg::cpu_bus_t    mcu_req,    // MCU
    input  wire  shouse_pkg::cpu_bus_t    snd_req,    // Sound CPU

    output logic [shouse_pkg::DATA_W-1:0] bus_rdata,
    output logic [shouse_pkg::DATA_W-1:0] alt_rdata   // Shared by MCU and sound CPU
);

    shouse_pkg::port_sel_t port_sel;    // Port 1 owner
    shouse_pkg::cpu_bus_t  alt_req;     // Request muxed onto port 1

    logic we0;
    logic we1;
    logic win_end;      // Last cycle of the owner's window

    // Owner follows whichever strobe fired last
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            port_sel <= shouse_pkg::SEL_MCU;
        end else if (mcu_cen) begin
            port_sel <= shouse_pkg::SEL_MCU;
        end else if (snd_cen) begin
            port_sel <= shouse_pkg::SEL_SND;
        end
    end

    // Port 1 request mux
    assign alt_req = (port_sel == shouse_pkg::SEL_SND) ? snd_req : mcu_req;

    // Window closes on the other requester's strobe
    // One write per window even when the request is held
    assign win_end = (port_sel == shouse_pkg::SEL_SND) ? mcu_cen : snd_cen;

    // Write enables from chip select and direction
    assign we0 = bus_req.cs && !bus_req.rnw;
    assign we1 = alt_req.cs && !alt_req.rnw && win_end;

    shouse_dual_ram u_ram (
        .clk    ( clk             ),
        // Port 0 to main bus
        .we0    ( we0             ),
        .addr0  ( bus_req.addr    ),
        .wdata0 ( bus_req.wdata   ),
        .rdata0 ( bus_rdata       ),
        // Port 1 to current owner
        .we1    ( we1             ),
        .addr1  ( alt_req.addr    ),
        .wdata1 ( alt_req.wdata   ),
        .rdata1 ( alt_rdata       )
    );

endmodule

`default_nettype wire

// File: shouse_tri.f
rtl/shouse_pkg.sv
rtl/shouse_cen_gen.sv
rtl/shouse_dual_ram.sv
rtl/shouse_triram.sv
rtl/shouse_tri_top.sv
tb/shouse_tri_checker.sv
tb/tb_shouse_tri.sv

// File: tb/shouse_tri_checker.sv
// Strobe and port-1 ownership assertions, bound into shouse_triram
// Checks start after the first reset edge, before that the strobes are undefined
`timescale 1ns/10ps
`default_nettype none

module shouse_tri_checker (
    input wire                        clk,
    input wire                        rst_n,
    input wire                        snd_cen,
    input wire                        mcu_cen,
    input wire shouse_pkg::port_sel_t port_sel
);

    logic seen_reset = 1'b0;    // Set by the first reset edge

    always @(posedge clk) begin
        if (!rst_n) begin
            seen_reset <= 1'b1;
        end
    end

    // Strobes never overlap
    a_excl: assert property (@(posedge clk) seen_reset |-> !(snd_cen && mcu_cen))
        else $error("snd_cen and mcu_cen high together");

    // Quiet strobes in reset
    a_rst: assert property (@(posedge clk) (seen_reset && !rst_n) |-> (!snd_cen && !mcu_cen))
        else $error("strobe active during reset");

    // Owner follows last strobe
    a_sel_snd: assert property (@(posedge clk)
        (seen_reset && rst_n && $past(rst_n) && $past(snd_cen))
        |-> port_sel == shouse_pkg::SEL_SND)
        else $error("port 1 not given to sound CPU after snd_cen");

    a_sel_mcu: assert property (@(posedge clk)
        (seen_reset && rst_n && $past(rst_n) && $past(mcu_cen))
        |-> port_sel == shouse_pkg::SEL_MCU)
        else $error("port 1 not given to MCU after mcu_cen");

endmodule

bind shouse_triram shouse_tri_checker u_checker (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .snd_cen  ( snd_cen  ),
    .mcu_cen  ( mcu_cen  ),
    .port_sel ( port_sel )
);

`default_nettype wire

// File: tb/shouse_tri_golden.txt
# name requester op addr(hex) data(hex); data is the expected value on reads
# requester B main bus, S sound, M MCU; op W write, R read and compare
# X sound write outside its window, C main and MCU write collision (MCU writes ~data)
# D sound read while the main bus writes ~data; data values drawn with $urandom
bus_wr B W 000 5a
bus_wr B W 001 c3
bus_wr B W 2a4 7e
bus_wr B W 7ff 19
bus_rd B R 000 5a
bus_rd B R 001 c3
bus_rd B R 2a4 7e
bus_rd B R 7ff 19
snd_to_bus S W 123 a7
snd_to_bus B R 123 a7
bus_to_snd B W 2f0 5e
bus_to_snd S R 2f0 5e
mcu_to_snd M W 456 c1
mcu_to_snd S R 456 c1
snd_outside S X 456 99
snd_outside S R 456 c1
snd_outside M R 456 c1
snd_to_mcu S W 3b8 d4
snd_to_mcu M R 3b8 d4
mcu_to_bus M W 100 3e
mcu_to_bus B R 100 3e
bus_to_mcu B W 6a1 b2
bus_to_mcu M R 6a1 b2
collide M C 07f 6d
collide B R 07f 6d
collide M R 07f 6d
collide S R 07f 6d
rd_wr_same B W 333 18
rd_wr_same S D 333 18
rd_wr_same B R 333 e7
rd_wr_same S R 333 e7
wrap_snd S W 7ff 84
wrap_snd B R 7ff 84
wrap_snd M R 7ff 84
wrap_mcu M W 000 f1
wrap_mcu S R 000 f1
wrap_mcu B R 000 f1
keep_bus B R 001 c3
keep_bus B R 2a4 7e
keep_alt S R 123 a7
keep_alt M R 2f0 5e

// File: tb/tb_shouse_tri.sv
// Golden-file testbench for the tri-port shared RAM
// Golden file read from tb/, so run from the project root
// Sound and MCU lines align to their own strobe and hold for one period
// Idle requesters carry random address and data with cs low
`timescale 1ns/10ps
`default_nettype none

module tb_shouse_tri;

    localparam int MAX_OPS = 128;
    localparam int NAME_W  = 8 * 24;

    logic                          clk;
    logic                          rst_n;
    shouse_pkg::cpu_bus_t          bus_req;
    shouse_pkg::cpu_bus_t          mcu_req;
    shouse_pkg::cpu_bus_t          snd_req;
    logic [shouse_pkg::DATA_W-1:0] bus_rdata;
    logic [shouse_pkg::DATA_W-1:0] alt_rdata;
    logic                          snd_cen;
    logic                          mcu_cen;

    // Golden operations
    logic [NAME_W-1:0]             op_name [MAX_OPS];
    logic [7:0]                    op_req  [MAX_OPS];   // B, S or M
    logic [7:0]                    op_code [MAX_OPS];   // W, R, X, C or D
    logic [shouse_pkg::ADDR_W-1:0] op_addr [MAX_OPS];
    logic [shouse_pkg::DATA_W-1:0] op_data [MAX_OPS];

    int   n_ops   = 0;
    int   errors  = 0;
    int   checks  = 0;
    logic loaded  = 1'b0;
    logic clocked = 1'b0;   // First clock edge seen
    logic rst_q   = 1'b0;   // rst_n as of the last edge
    int   cyc     = 0;      // Cycles since reset release

    shouse_tri_top u_dut (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .bus_req   ( bus_req   ),
        .mcu_req   ( mcu_req   ),
        .snd_req   ( snd_req   ),
        .bus_rdata ( bus_rdata ),
        .alt_rdata ( alt_rdata ),
        .snd_cen   ( snd_cen   ),
        .mcu_cen   ( mcu_cen   )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    task automatic check_value(input logic [NAME_W-1:0] name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %0s expected %0h actual %0h", name, exp, act);
        end
    endtask

    // Deselected request with random payload
    function automatic shouse_pkg::cpu_bus_t idle_request();
        shouse_pkg::cpu_bus_t r;
        logic [31:0]          rnd;
        rnd     = $urandom;
        r.cs    = 1'b0;
        r.rnw   = rnd[31];
        r.addr  = rnd[shouse_pkg::ADDR_W-1:0];
        r.wdata = rnd[23:16];
        return r;
    endfunction

    function automatic shouse_pkg::cpu_bus_t make_request(
        input logic rnw, input logic [shouse_pkg::ADDR_W-1:0] addr,
        input logic [shouse_pkg::DATA_W-1:0] data);
        shouse_pkg::cpu_bus_t r;
        r.cs    = 1'b1;
        r.rnw   = rnw;
        r.addr  = addr;
        r.wdata = data;
        return r;
    endfunction

    task automatic load_golden();
        int    fd;
        int    rc;
        string line;
        logic [NAME_W-1:0]             t_name;
        logic [7:0]                    t_req;
        logic [7:0]                    t_op;
        logic [shouse_pkg::ADDR_W-1:0] t_addr;
        logic [shouse_pkg::DATA_W-1:0] t_data;
        fd = $fopen("tb/shouse_tri_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open golden file tb/shouse_tri_golden.txt");
        end else begin
            while (!$feof(fd) && n_ops < MAX_OPS) begin
                rc = $fgets(line, fd);
                if (rc > 0 && line.len() > 2 && line.getc(0) != "#") begin
                    rc = $sscanf(line, "%s %s %s %h %h", t_name, t_req, t_op, t_addr, t_data);
                    if (rc == 5) begin
                        op_name[n_ops] = t_name;
                        op_req[n_ops]  = t_req;
                        op_code[n_ops] = t_op;
                        op_addr[n_ops] = t_addr;
                        op_data[n_ops] = t_data;
                        n_ops++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Called on a falling edge, returns on the falling edge of a strobe cycle
    task automatic wait_for_snd();
        while (snd_cen !== 1'b1) @(negedge clk);
    endtask

    task automatic wait_for_mcu();
        while (mcu_cen !== 1'b1) @(negedge clk);
    endtask

    // Main bus, one cycle per line
    task automatic run_bus_op(input int i);
        bus_req = make_request(op_code[i] == "R", op_addr[i], op_data[i]);
        @(negedge clk);
        if (op_code[i] == "R") begin
            check_value(op_name[i], 32'(op_data[i]), 32'(bus_rdata));
        end
        bus_req = idle_request();
    endtask

    task automatic run_snd_op(input int i);
        if (op_code[i] == "X") begin
            // Held only through the MCU window
            wait_for_mcu();
            @(negedge clk);
            snd_req = make_request(1'b0, op_addr[i], op_data[i]);
            @(negedge clk);
            wait_for_snd();
            snd_req = idle_request();
        end else begin
            wait_for_snd();
            snd_req = make_request(op_code[i] != "W", op_addr[i], op_data[i]);
            @(negedge clk);
            if (op_code[i] == "D") begin
                bus_req = make_request(1'b0, op_addr[i], ~op_data[i]);  // Lands on the read edge
            end
            @(negedge clk);
            wait_for_mcu();
            bus_req = idle_request();
            if (op_code[i] != "W") begin
                check_value(op_name[i], 32'(op_data[i]), 32'(alt_rdata));
            end
            @(negedge clk);
            wait_for_snd();
            snd_req = idle_request();
        end
    endtask

    task automatic run_mcu_op(input int i);
        logic [shouse_pkg::DATA_W-1:0] wdata;
        wdata = (op_code[i] == "C") ? ~op_data[i] : op_data[i];
        wait_for_mcu();
        mcu_req = make_request(op_code[i] == "R", op_addr[i], wdata);
        @(negedge clk);
        wait_for_snd();
        if (op_code[i] == "C") begin
            bus_req = make_request(1'b0, op_addr[i], op_data[i]);  // Same edge as MCU write
        end
        if (op_code[i] == "R") begin
            check_value(op_name[i], 32'(op_data[i]), 32'(alt_rdata));
        end
        @(negedge clk);
        bus_req = idle_request();
        wait_for_mcu();
        mcu_req = idle_request();
    endtask

    // Strobe pattern, sampled mid-cycle
    always @(posedge clk) begin
        clocked <= 1'b1;
        rst_q   <= rst_n;
    end

    always @(negedge clk) begin
        if (clocked) begin
            if (!rst_q) begin
                check_value("strobe_reset_snd", 32'd0, 32'(snd_cen));
                check_value("strobe_reset_mcu", 32'd0, 32'(mcu_cen));
            end else begin
                check_value("strobe_snd", 32'((cyc % shouse_pkg::CEN_PERIOD) == 0),
                            32'(snd_cen));
                check_value("strobe_mcu",
                            32'((cyc % shouse_pkg::CEN_PERIOD) == shouse_pkg::CEN_PERIOD / 2),
                            32'(mcu_cen));
                cyc++;
            end
        end
    end

    // Watchdog sized from the golden length
    initial begin
        wait (loaded);
        #(n_ops * shouse_pkg::CEN_PERIOD * 8 + 2000);
        $display("Timeout, golden operations did not finish in time");
        $display("Errors: %0d of %0d checks", errors, checks);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(32'he952_03e0));
        rst_n   = 1'b0;
        bus_req = idle_request();
        mcu_req = idle_request();
        snd_req = idle_request();
        load_golden();
        if (n_ops == 0) begin
            $display("Golden file holds no operations");
            errors++;
        end
        loaded = 1'b1;
        repeat (2) @(negedge clk);   // Two reset edges
        rst_n = 1'b1;
        for (int i = 0; i < n_ops; i++) begin
            case (op_req[i])
                "B":     run_bus_op(i);
                "S":     run_snd_op(i);
                "M":     run_mcu_op(i);
                default: begin
                    $display("Unknown requester on golden line %0d", i);
                    errors++;
                end
            endcase
        end
        repeat (shouse_pkg::CEN_PERIOD) @(negedge clk);
        $display("Errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
